/* compile.f */
design/rv_exec_pkg.sv
design/instr_decoder.sv
design/alu.sv
design/execute_unit.sv
design/arch_state.sv
design/exec_core.sv
test/exec_core_tb.sv

/* design/alu.sv */
`timescale 1ns/100ps

module alu (
  input  logic [3:0]  alu_op,
  input  logic [31:0] operand_a,
  input  logic [31:0] operand_b,
  output logic [31:0] result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = operand_b[4:0];
  assign lt_signed   = $signed(operand_a) < $signed(operand_b);
  assign lt_unsigned = operand_a < operand_b;

  // ALU_BLT and ALU_BLTU share the slt and sltu codes
  always_comb begin
    case (alu_op)
      rv_exec_pkg::ALU_ADD:    result = operand_a + operand_b;
      rv_exec_pkg::ALU_SUB:    result = operand_a - operand_b;
      rv_exec_pkg::ALU_SLL:    result = operand_a << shamt;
      rv_exec_pkg::ALU_SLT:    result = {31'd0, lt_signed};
      rv_exec_pkg::ALU_SLTU:   result = {31'd0, lt_unsigned};
      rv_exec_pkg::ALU_XOR:    result = operand_a ^ operand_b;
      rv_exec_pkg::ALU_SRL:    result = operand_a >> shamt;
      rv_exec_pkg::ALU_SRA:    result = $signed(operand_a) >>> shamt;
      rv_exec_pkg::ALU_OR:     result = operand_a | operand_b;
      rv_exec_pkg::ALU_AND:    result = operand_a & operand_b;
      rv_exec_pkg::ALU_PASS_B: result = operand_b;
      rv_exec_pkg::ALU_BEQ:    result = {31'd0, operand_a == operand_b};
      rv_exec_pkg::ALU_BNE:    result = {31'd0, operand_a != operand_b};
      rv_exec_pkg::ALU_BGE:    result = {31'd0, !lt_signed};
      rv_exec_pkg::ALU_BGEU:   result = {31'd0, !lt_unsigned};
      default:                 result = 32'd0;
    endcase
  end

endmodule

/* design/arch_state.sv */
`timescale 1ns/100ps

module arch_state (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] src1,
  output logic [31:0] src2,
  input  logic        rd_we,
  input  logic [4:0]  rd,
  input  logic [31:0] rd_wdata,
  input  logic [11:0] csr_addr,
  output logic [31:0] csr_rdata,
  input  logic        csr_we,
  input  logic [11:0] csr_waddr,
  input  logic [31:0] csr_wdata,
  input  logic        trap_we,
  input  logic [31:0] trap_pc
);

  logic [31:0] regs [1:31];
  logic [31:0] mepc;
  logic [31:0] mcause;
  logic [31:0] mtvec;
  logic [31:0] mepc_next;
  logic [31:0] mcause_next;
  logic [31:0] mtvec_next;

  function automatic logic [31:0] read_gpr(input logic [4:0] addr);
    if (addr == 5'd0)
      return 32'd0;
    else if (rd_we && rd == addr)
      return rd_wdata;
    else
      return regs[addr];
  endfunction

  always_comb src1 = read_gpr(rs1);
  always_comb src2 = read_gpr(rs2);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= 32'd0;
    end else if (rd_we && rd != 5'd0) begin
      regs[rd] <= rd_wdata;
    end
  end

  // ecall wins over a csr write to mepc or mcause
  always_comb begin
    mepc_next   = mepc;
    mcause_next = mcause;
    mtvec_next  = mtvec;
    if (csr_we) begin
      case (csr_waddr)
        rv_exec_pkg::CSR_MEPC:   mepc_next = csr_wdata;
        rv_exec_pkg::CSR_MCAUSE: mcause_next = csr_wdata;
        rv_exec_pkg::CSR_MTVEC:  mtvec_next = csr_wdata;
        default: begin
        end
      endcase
    end
    if (trap_we) begin
      mepc_next   = trap_pc;
      mcause_next = rv_exec_pkg::MCAUSE_ECALL;
    end
  end

  // reading the next values gives the bypass
  always_comb begin
    case (csr_addr)
      rv_exec_pkg::CSR_MEPC:   csr_rdata = mepc_next;
      rv_exec_pkg::CSR_MCAUSE: csr_rdata = mcause_next;
      rv_exec_pkg::CSR_MTVEC:  csr_rdata = mtvec_next;
      default:                 csr_rdata = 32'd0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mepc   <= 32'd0;
      mcause <= 32'd0;
      mtvec  <= 32'd0;
    end else begin
      mepc   <= mepc_next;
      mcause <= mcause_next;
      mtvec  <= mtvec_next;
    end
  end

  zero_reg_reads_zero: assert property (
    @(posedge clock) disable iff (reset)
    (rs1 == 5'd0 |-> src1 == 32'd0) and (rs2 == 5'd0 |-> src2 == 32'd0));

endmodule

/* design/exec_core.sv */
`timescale 1ns/100ps

module exec_core (
  input  logic        clock,
  input  logic        reset,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  input  logic [31:0] pc,
  input  logic        stall,
  output logic        npc_valid,
  output logic [31:0] npc,
  output logic        redirect,
  output logic        retire_we,
  output logic [4:0]  retire_rd,
  output logic [31:0] retire_wdata
);

  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  dec_rd;
  logic [31:0] imm;
  logic [3:0]  alu_op;
  logic [1:0]  opb_sel;
  logic        use_pc_a;
  logic [2:0]  npc_sel;
  logic [1:0]  wb_sel;
  logic        dec_rd_we;
  logic [11:0] csr_addr;
  logic [1:0]  csr_op;
  logic        csr_use_imm;
  logic        is_ecall;
  logic        is_mret;
  logic [31:0] src1;
  logic [31:0] src2;
  logic [31:0] csr_rdata;
  logic [3:0]  alu_op_q;
  logic [31:0] operand_a;
  logic [31:0] operand_b;
  logic [31:0] alu_result;
  logic        csr_we;
  logic [11:0] csr_waddr;
  logic [31:0] csr_wdata;
  logic        trap_we;
  logic [31:0] trap_pc;
  logic        accept;

  // the word presented during a redirect is on the wrong path
  assign accept = instr_valid && !stall && !redirect;

  instr_decoder decoder_i (
    .instr       (instr),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (dec_rd),
    .imm         (imm),
    .alu_op      (alu_op),
    .opb_sel     (opb_sel),
    .use_pc_a    (use_pc_a),
    .npc_sel     (npc_sel),
    .wb_sel      (wb_sel),
    .rd_we       (dec_rd_we),
    .csr_addr    (csr_addr),
    .csr_op      (csr_op),
    .csr_use_imm (csr_use_imm),
    .is_ecall    (is_ecall),
    .is_mret     (is_mret)
  );

  arch_state state_i (
    .clock     (clock),
    .reset     (reset),
    .rs1       (rs1),
    .rs2       (rs2),
    .src1      (src1),
    .src2      (src2),
    .rd_we     (retire_we),
    .rd        (retire_rd),
    .rd_wdata  (retire_wdata),
    .csr_addr  (csr_addr),
    .csr_rdata (csr_rdata),
    .csr_we    (csr_we),
    .csr_waddr (csr_waddr),
    .csr_wdata (csr_wdata),
    .trap_we   (trap_we),
    .trap_pc   (trap_pc)
  );

  execute_unit exec_i (
    .clock       (clock),
    .reset       (reset),
    .stall       (stall),
    .accept      (accept),
    .pc          (pc),
    .src1        (src1),
    .src2        (src2),
    .imm         (imm),
    .csr_rdata   (csr_rdata),
    .alu_op      (alu_op),
    .opb_sel     (opb_sel),
    .use_pc_a    (use_pc_a),
    .npc_sel     (npc_sel),
    .wb_sel      (wb_sel),
    .dec_rd_we   (dec_rd_we),
    .dec_rd      (dec_rd),
    .csr_addr    (csr_addr),
    .csr_op      (csr_op),
    .csr_use_imm (csr_use_imm),
    .is_ecall    (is_ecall),
    .is_mret     (is_mret),
    .alu_op_q    (alu_op_q),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .alu_result  (alu_result),
    .npc_valid   (npc_valid),
    .npc         (npc),
    .redirect    (redirect),
    .rd_we       (retire_we),
    .rd          (retire_rd),
    .rd_wdata    (retire_wdata),
    .csr_we      (csr_we),
    .csr_waddr   (csr_waddr),
    .csr_wdata   (csr_wdata),
    .trap_we     (trap_we),
    .trap_pc     (trap_pc)
  );

  alu alu_i (
    .alu_op    (alu_op_q),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .result    (alu_result)
  );

endmodule

/* design/execute_unit.sv */
`timescale 1ns/100ps

module execute_unit (
  input  logic        clock,
  input  logic        reset,
  input  logic        stall,
  input  logic        accept,
  input  logic [31:0] pc,
  input  logic [31:0] src1,
  input  logic [31:0] src2,
  input  logic [31:0] imm,
  input  logic [31:0] csr_rdata,
  input  logic [3:0]  alu_op,
  input  logic [1:0]  opb_sel,
  input  logic        use_pc_a,
  input  logic [2:0]  npc_sel,
  input  logic [1:0]  wb_sel,
  input  logic        dec_rd_we,
  input  logic [4:0]  dec_rd,
  input  logic [11:0] csr_addr,
  input  logic [1:0]  csr_op,
  input  logic        csr_use_imm,
  input  logic        is_ecall,
  input  logic        is_mret,
  output logic [3:0]  alu_op_q,
  output logic [31:0] operand_a,
  output logic [31:0] operand_b,
  input  logic [31:0] alu_result,
  output logic        npc_valid,
  output logic [31:0] npc,
  output logic        redirect,
  output logic        rd_we,
  output logic [4:0]  rd,
  output logic [31:0] rd_wdata,
  output logic        csr_we,
  output logic [11:0] csr_waddr,
  output logic [31:0] csr_wdata,
  output logic        trap_we,
  output logic [31:0] trap_pc
);

  logic [31:0] snpc;
  logic [31:0] dnpc;
  logic [2:0]  npc_sel_q;
  logic [1:0]  wb_sel_q;
  logic        rd_we_q;
  logic [31:0] csr_old;
  logic [31:0] csr_src;
  logic [1:0]  csr_op_q;
  logic        ecall_q;
  logic        mret_q;
  logic        pending;
  logic        retire;

  // pending limits the architectural writes to the first retire cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      npc_valid <= 1'b0;
      pending   <= 1'b0;
    end else if (!stall) begin
      npc_valid <= accept;
      pending   <= accept;
    end else begin
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      alu_op_q  <= alu_op;
      operand_a <= use_pc_a ? pc : src1;
      case (opb_sel)
        rv_exec_pkg::OPB_IMM: operand_b <= imm;
        rv_exec_pkg::OPB_CSR: operand_b <= csr_rdata;
        default:              operand_b <= src2;
      endcase
      snpc      <= pc + 32'd4;
      dnpc      <= pc + imm;
      trap_pc   <= pc;
      npc_sel_q <= npc_sel;
      wb_sel_q  <= wb_sel;
      rd_we_q   <= dec_rd_we;
      rd        <= dec_rd;
      csr_old   <= csr_rdata;
      csr_src   <= csr_use_imm ? imm : src1;
      csr_op_q  <= csr_op;
      csr_waddr <= csr_addr;
      ecall_q   <= is_ecall;
      mret_q    <= is_mret;
    end
  end

  always_comb begin
    case (npc_sel_q)
      rv_exec_pkg::NPC_JAL:    npc = dnpc;
      rv_exec_pkg::NPC_JALR:   npc = {alu_result[31:1], 1'b0};
      rv_exec_pkg::NPC_BRANCH: npc = alu_result[0] ? dnpc : snpc;
      rv_exec_pkg::NPC_CSR: begin
        // mtvec keeps its mode in the two low bits
        if (mret_q)
          npc = {csr_old[31:1], 1'b0};
        else
          npc = {csr_old[31:2], 2'b00};
      end
      default:                 npc = snpc;
    endcase
  end

  always_comb begin
    case (wb_sel_q)
      rv_exec_pkg::WB_SNPC: rd_wdata = snpc;
      rv_exec_pkg::WB_DNPC: rd_wdata = dnpc;
      rv_exec_pkg::WB_CSR:  rd_wdata = csr_old;
      default:              rd_wdata = alu_result;
    endcase
  end

  always_comb begin
    case (csr_op_q)
      rv_exec_pkg::CSR_WRITE: csr_wdata = csr_src;
      rv_exec_pkg::CSR_SET:   csr_wdata = csr_old | csr_src;
      rv_exec_pkg::CSR_CLEAR: csr_wdata = csr_old & ~csr_src;
      default:                csr_wdata = csr_old;
    endcase
  end

  assign redirect = npc_valid && (npc != snpc);
  assign retire   = npc_valid && pending;
  assign rd_we    = retire && rd_we_q;
  assign csr_we   = retire && (csr_op_q != rv_exec_pkg::CSR_NONE);
  assign trap_we  = retire && ecall_q;

  redirect_needs_valid: assert property (
    @(posedge clock) disable iff (reset) redirect |-> npc_valid);

  npc_halfword_aligned: assert property (
    @(posedge clock) disable iff (reset) npc_valid |-> npc[0] == 1'b0);

endmodule

/* design/instr_decoder.sv */
`timescale 1ns/100ps

module instr_decoder (
  input  logic [31:0] instr,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  output logic [4:0]  rd,
  output logic [31:0] imm,
  output logic [3:0]  alu_op,
  output logic [1:0]  opb_sel,
  output logic        use_pc_a,
  output logic [2:0]  npc_sel,
  output logic [1:0]  wb_sel,
  output logic        rd_we,
  output logic [11:0] csr_addr,
  output logic [1:0]  csr_op,
  output logic        csr_use_imm,
  output logic        is_ecall,
  output logic        is_mret
);

  rv_exec_pkg::rv_instr_t word;
  logic [31:0] imm_i;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [3:0]  arith_op;
  logic        writes_rd;

  assign word = instr;
  assign rs1  = word.r.rs1;
  assign rs2  = word.r.rs2;
  assign rd   = word.r.rd;

  assign imm_i = {{20{word.i.imm[11]}}, word.i.imm};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'd0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // sub only exists in the register form, sra in both
  always_comb begin
    case (word.r.funct3)
      rv_exec_pkg::F3_ADD: begin
        if (word.r.opcode == rv_exec_pkg::OP_REG && word.r.funct7 == rv_exec_pkg::F7_ALT)
          arith_op = rv_exec_pkg::ALU_SUB;
        else
          arith_op = rv_exec_pkg::ALU_ADD;
      end
      rv_exec_pkg::F3_SLL:  arith_op = rv_exec_pkg::ALU_SLL;
      rv_exec_pkg::F3_SLT:  arith_op = rv_exec_pkg::ALU_SLT;
      rv_exec_pkg::F3_SLTU: arith_op = rv_exec_pkg::ALU_SLTU;
      rv_exec_pkg::F3_XOR:  arith_op = rv_exec_pkg::ALU_XOR;
      rv_exec_pkg::F3_SR: begin
        if (word.r.funct7 == rv_exec_pkg::F7_ALT)
          arith_op = rv_exec_pkg::ALU_SRA;
        else
          arith_op = rv_exec_pkg::ALU_SRL;
      end
      rv_exec_pkg::F3_OR:   arith_op = rv_exec_pkg::ALU_OR;
      default:              arith_op = rv_exec_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    imm         = imm_i;
    alu_op      = rv_exec_pkg::ALU_ADD;
    opb_sel     = rv_exec_pkg::OPB_REG;
    use_pc_a    = 1'b0;
    npc_sel     = rv_exec_pkg::NPC_SEQ;
    wb_sel      = rv_exec_pkg::WB_ALU;
    writes_rd   = 1'b0;
    csr_addr    = word.i.imm;
    csr_op      = rv_exec_pkg::CSR_NONE;
    csr_use_imm = 1'b0;
    is_ecall    = 1'b0;
    is_mret     = 1'b0;
    case (word.r.opcode)
      rv_exec_pkg::OP_LUI: begin
        imm       = imm_u;
        alu_op    = rv_exec_pkg::ALU_PASS_B;
        opb_sel   = rv_exec_pkg::OPB_IMM;
        writes_rd = 1'b1;
      end
      rv_exec_pkg::OP_AUIPC: begin
        imm       = imm_u;
        opb_sel   = rv_exec_pkg::OPB_IMM;
        use_pc_a  = 1'b1;
        writes_rd = 1'b1;
      end
      rv_exec_pkg::OP_JAL: begin
        imm       = imm_j;
        npc_sel   = rv_exec_pkg::NPC_JAL;
        wb_sel    = rv_exec_pkg::WB_SNPC;
        writes_rd = 1'b1;
      end
      rv_exec_pkg::OP_JALR: begin
        opb_sel   = rv_exec_pkg::OPB_IMM;
        npc_sel   = rv_exec_pkg::NPC_JALR;
        wb_sel    = rv_exec_pkg::WB_SNPC;
        writes_rd = 1'b1;
      end
      rv_exec_pkg::OP_BRANCH: begin
        imm     = imm_b;
        npc_sel = rv_exec_pkg::NPC_BRANCH;
        case (word.r.funct3)
          rv_exec_pkg::F3_BEQ:  alu_op = rv_exec_pkg::ALU_BEQ;
          rv_exec_pkg::F3_BNE:  alu_op = rv_exec_pkg::ALU_BNE;
          rv_exec_pkg::F3_BLT:  alu_op = rv_exec_pkg::ALU_BLT;
          rv_exec_pkg::F3_BGE:  alu_op = rv_exec_pkg::ALU_BGE;
          rv_exec_pkg::F3_BLTU: alu_op = rv_exec_pkg::ALU_BLTU;
          rv_exec_pkg::F3_BGEU: alu_op = rv_exec_pkg::ALU_BGEU;
          // reserved funct3 falls through as a no-op
          default:              npc_sel = rv_exec_pkg::NPC_SEQ;
        endcase
      end
      rv_exec_pkg::OP_IMM: begin
        alu_op    = arith_op;
        opb_sel   = rv_exec_pkg::OPB_IMM;
        writes_rd = 1'b1;
      end
      rv_exec_pkg::OP_REG: begin
        alu_op    = arith_op;
        writes_rd = 1'b1;
      end
      rv_exec_pkg::OP_SYSTEM: begin
        if (word.r.funct3 != rv_exec_pkg::F3_PRIV) begin
          if (word.r.funct3[1:0] != rv_exec_pkg::CSR_NONE) begin
            // zimm rides in the immediate, rd gets the old csr value
            imm         = {27'd0, word.r.rs1};
            alu_op      = rv_exec_pkg::ALU_PASS_B;
            opb_sel     = rv_exec_pkg::OPB_CSR;
            wb_sel      = rv_exec_pkg::WB_CSR;
            csr_op      = word.r.funct3[1:0];
            csr_use_imm = word.r.funct3[2];
            writes_rd   = 1'b1;
          end
        end else if (word.i.imm == rv_exec_pkg::FUNCT12_ECALL) begin
          is_ecall = 1'b1;
          npc_sel  = rv_exec_pkg::NPC_CSR;
          csr_addr = rv_exec_pkg::CSR_MTVEC;
        end else if (word.i.imm == rv_exec_pkg::FUNCT12_MRET) begin
          is_mret  = 1'b1;
          npc_sel  = rv_exec_pkg::NPC_CSR;
          csr_addr = rv_exec_pkg::CSR_MEPC;
        end
      end
      default: begin
      end
    endcase
  end

  assign rd_we = writes_rd && (word.r.rd != 5'd0);

endmodule

/* design/rv_exec_pkg.sv */
package rv_exec_pkg;

  // base opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // funct3 for register and immediate arithmetic
  localparam logic [2:0] F3_ADD  = 3'd0;
  localparam logic [2:0] F3_SLL  = 3'd1;
  localparam logic [2:0] F3_SLT  = 3'd2;
  localparam logic [2:0] F3_SLTU = 3'd3;
  localparam logic [2:0] F3_XOR  = 3'd4;
  localparam logic [2:0] F3_SR   = 3'd5;
  localparam logic [2:0] F3_OR   = 3'd6;
  localparam logic [2:0] F3_AND  = 3'd7;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ  = 3'd0;
  localparam logic [2:0] F3_BNE  = 3'd1;
  localparam logic [2:0] F3_BLT  = 3'd4;
  localparam logic [2:0] F3_BGE  = 3'd5;
  localparam logic [2:0] F3_BLTU = 3'd6;
  localparam logic [2:0] F3_BGEU = 3'd7;

  // funct3 zero of the system space holds ecall and mret
  localparam logic [2:0]  F3_PRIV       = 3'd0;
  localparam logic [6:0]  F7_ALT        = 7'b0100000;
  localparam logic [11:0] FUNCT12_ECALL = 12'h000;
  localparam logic [11:0] FUNCT12_MRET  = 12'h302;

  localparam logic [3:0] ALU_ADD    = 4'd0;
  localparam logic [3:0] ALU_SUB    = 4'd1;
  localparam logic [3:0] ALU_SLL    = 4'd2;
  localparam logic [3:0] ALU_SLT    = 4'd3;
  localparam logic [3:0] ALU_SLTU   = 4'd4;
  localparam logic [3:0] ALU_XOR    = 4'd5;
  localparam logic [3:0] ALU_SRL    = 4'd6;
  localparam logic [3:0] ALU_SRA    = 4'd7;
  localparam logic [3:0] ALU_OR     = 4'd8;
  localparam logic [3:0] ALU_AND    = 4'd9;
  localparam logic [3:0] ALU_PASS_B = 4'd10;
  localparam logic [3:0] ALU_BEQ    = 4'd11;
  localparam logic [3:0] ALU_BNE    = 4'd12;
  localparam logic [3:0] ALU_BGE    = 4'd13;
  localparam logic [3:0] ALU_BGEU   = 4'd14;
  // a less-than branch is taken exactly when the set-less-than result is 1
  localparam logic [3:0] ALU_BLT    = ALU_SLT;
  localparam logic [3:0] ALU_BLTU   = ALU_SLTU;

  localparam logic [2:0] NPC_SEQ    = 3'd0;
  localparam logic [2:0] NPC_JAL    = 3'd1;
  localparam logic [2:0] NPC_JALR   = 3'd2;
  localparam logic [2:0] NPC_BRANCH = 3'd3;
  localparam logic [2:0] NPC_CSR    = 3'd4;

  localparam logic [1:0] WB_ALU  = 2'd0;
  localparam logic [1:0] WB_SNPC = 2'd1;
  localparam logic [1:0] WB_DNPC = 2'd2;
  localparam logic [1:0] WB_CSR  = 2'd3;

  localparam logic [1:0] OPB_REG = 2'd0;
  localparam logic [1:0] OPB_IMM = 2'd1;
  localparam logic [1:0] OPB_CSR = 2'd2;

  // same encoding as funct3[1:0] of csrrw, csrrs and csrrc
  localparam logic [1:0] CSR_NONE  = 2'd0;
  localparam logic [1:0] CSR_WRITE = 2'd1;
  localparam logic [1:0] CSR_SET   = 2'd2;
  localparam logic [1:0] CSR_CLEAR = 2'd3;

  localparam logic [11:0] CSR_MEPC   = 12'h341;
  localparam logic [11:0] CSR_MCAUSE = 12'h342;
  localparam logic [11:0] CSR_MTVEC  = 12'h305;

  localparam logic [31:0] MCAUSE_ECALL = 32'd11;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } rv_instr_t;

endpackage

/* test/exec_core_tb.sv */
`timescale 1ns/100ps

module exec_core_tb;

  logic        clock;
  logic        reset;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        stall;
  logic        npc_valid;
  logic [31:0] npc;
  logic        redirect;
  logic        retire_we;
  logic [4:0]  retire_rd;
  logic [31:0] retire_wdata;

  logic [31:0] imem [0:1023];
  logic [2:0]  phase_of [0:1023];
  logic [31:0] mreg [0:31];
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic [31:0] m_mtvec;
  logic [31:0] nxt_npc;
  logic        nxt_we;
  logic [4:0]  nxt_rd;
  logic [31:0] nxt_wdata;
  logic        exp_valid;
  logic [31:0] exp_npc;
  logic [31:0] exp_pc;
  logic        exp_we;
  logic [4:0]  exp_rd;
  logic [31:0] exp_wdata;
  string       exp_test;
  int          errors;
  int          wp;

  exec_core dut_i (
    .clock        (clock),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .pc           (pc),
    .stall        (stall),
    .npc_valid    (npc_valid),
    .npc          (npc),
    .redirect     (redirect),
    .retire_we    (retire_we),
    .retire_rd    (retire_rd),
    .retire_wdata (retire_wdata)
  );

  always #20 clock = ~clock;

  function automatic string phase_name(input logic [2:0] ph);
    case (ph)
      3'd1:    return "alu_random";
      3'd2:    return "branch_jump";
      3'd3:    return "csr_trap";
      3'd4:    return "stall";
      default: return "reset";
    endcase
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] word, input logic [2:0] ph);
    imem[wp] = word;
    phase_of[wp] = ph;
    wp++;
  endtask

  // one random arithmetic instruction over x0..x7 so that sources often depend on the last rd
  function automatic logic [31:0] random_alu();
    logic [2:0]  kind;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    kind = 3'($urandom % 8);
    f3 = 3'($urandom);
    imm = 12'($urandom);
    f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2) ? 7'h20 : 7'h00;
    if (kind < 3)
      return enc_r(f7, 5'($urandom % 8), 5'($urandom % 8), f3, 5'($urandom % 8), 7'b0110011);
    if (kind < 6) begin
      if (f3 == 3'd1)
        imm[11:5] = 7'h00;
      if (f3 == 3'd5)
        imm[11:5] = ($urandom % 2) ? 7'h20 : 7'h00;
      return enc_i(imm, 5'($urandom % 8), f3, 5'($urandom % 8), 7'b0010011);
    end
    return {20'($urandom), 5'($urandom % 8), (kind == 3'd6) ? 7'b0110111 : 7'b0010111};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
      input logic is_reg, input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return (is_reg && alt) ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // ISA reference for one accepted instruction
  task automatic exec_model(input logic [31:0] w, input logic [31:0] p);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] old;
    logic [31:0] src;
    logic        taken;
    logic        wr;
    a = mreg[w[19:15]];
    b = mreg[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    nxt_npc = p + 32'd4;
    nxt_wdata = 32'd0;
    wr = 1'b0;
    taken = 1'b0;
    case (w[6:0])
      7'b0110111: begin
        wr = 1'b1;
        nxt_wdata = {w[31:12], 12'd0};
      end
      7'b0010111: begin
        wr = 1'b1;
        nxt_wdata = p + {w[31:12], 12'd0};
      end
      7'b1101111: begin
        wr = 1'b1;
        nxt_wdata = p + 32'd4;
        nxt_npc = p + imm_j;
      end
      7'b1100111: begin
        wr = 1'b1;
        nxt_wdata = p + 32'd4;
        nxt_npc = (a + imm_i) & ~32'd1;
      end
      7'b1100011: begin
        case (w[14:12])
          3'd0: taken = a == b;
          3'd1: taken = a != b;
          3'd4: taken = $signed(a) < $signed(b);
          3'd5: taken = $signed(a) >= $signed(b);
          3'd6: taken = a < b;
          3'd7: taken = a >= b;
          default: taken = 1'b0;
        endcase
        if (taken)
          nxt_npc = p + imm_b;
      end
      7'b0010011: begin
        wr = 1'b1;
        nxt_wdata = alu_ref(w[14:12], w[30], 1'b0, a, imm_i);
      end
      7'b0110011: begin
        wr = 1'b1;
        nxt_wdata = alu_ref(w[14:12], w[30], 1'b1, a, b);
      end
      7'b1110011: begin
        if (w[14:12] != 3'd0 && w[13:12] != 2'd0) begin
          case (w[31:20])
            12'h341: old = m_mepc;
            12'h342: old = m_mcause;
            12'h305: old = m_mtvec;
            default: old = 32'd0;
          endcase
          src = w[14] ? {27'd0, w[19:15]} : a;
          wr = 1'b1;
          nxt_wdata = old;
          if (w[13:12] == 2'd2)
            src = old | src;
          else if (w[13:12] == 2'd3)
            src = old & ~src;
          case (w[31:20])
            12'h341: m_mepc = src;
            12'h342: m_mcause = src;
            12'h305: m_mtvec = src;
            default: ;
          endcase
        end else if (w[14:12] == 3'd0 && w[31:20] == 12'h000) begin
          m_mepc = p;
          m_mcause = 32'd11;
          nxt_npc = m_mtvec & ~32'd3;
        end else if (w[14:12] == 3'd0 && w[31:20] == 12'h302) begin
          nxt_npc = m_mepc & ~32'd1;
        end
      end
      default: ;
    endcase
    nxt_rd = w[11:7];
    nxt_we = wr && (nxt_rd != 5'd0);
    if (nxt_we)
      mreg[nxt_rd] = nxt_wdata;
  endtask

  task automatic report_value(input string what, input logic [31:0] expected,
      input logic [31:0] actual);
    errors++;
    $display("ERROR %s %s expected %h actual %h", exp_test, what, expected, actual);
  endtask

  task automatic check_state();
    for (int i = 1; i < 32; i++) begin
      if (dut_i.state_i.regs[i] !== mreg[i])
        report_value($sformatf("x%0d", i), mreg[i], dut_i.state_i.regs[i]);
    end
    if (dut_i.state_i.mtvec !== m_mtvec)
      report_value("mtvec", m_mtvec, dut_i.state_i.mtvec);
  endtask

  npc_valid_matches: assert property (@(posedge clock) disable iff (reset)
    npc_valid == exp_valid)
    else report_value("npc_valid", 32'(exp_valid), 32'($sampled(npc_valid)));

  idle_outputs_low: assert property (@(posedge clock) disable iff (reset)
    !npc_valid |-> !redirect && !retire_we)
    else begin
      errors++;
      $display("redirect or retire_we rose while npc_valid was low");
    end

  npc_matches: assert property (@(posedge clock) disable iff (reset)
    npc_valid |-> npc == exp_npc)
    else report_value("npc", exp_npc, $sampled(npc));

  redirect_matches: assert property (@(posedge clock) disable iff (reset)
    npc_valid |-> redirect == (exp_npc != exp_pc + 32'd4))
    else report_value("redirect", 32'(exp_npc != exp_pc + 32'd4), 32'($sampled(redirect)));

  retire_we_matches: assert property (@(posedge clock) disable iff (reset)
    npc_valid && !$past(npc_valid && stall) |-> retire_we == exp_we)
    else report_value("retire_we", 32'(exp_we), 32'($sampled(retire_we)));

  retire_rd_matches: assert property (@(posedge clock) disable iff (reset)
    retire_we |-> retire_rd == exp_rd)
    else report_value("retire_rd", 32'(exp_rd), 32'($sampled(retire_rd)));

  retire_wdata_matches: assert property (@(posedge clock) disable iff (reset)
    retire_we |-> retire_wdata == exp_wdata)
    else report_value("retire_wdata", exp_wdata, $sampled(retire_wdata));

  // a held retire must not write a second time
  stalled_retire_holds: assert property (@(posedge clock) disable iff (reset)
    npc_valid && $past(npc_valid && stall) |-> !retire_we && $stable(retire_wdata))
    else begin
      errors++;
      $display("retire repeated or changed while the retiring instruction was stalled");
    end

  initial begin
    logic [31:0] fetch_pc;
    logic [31:0] end_pc;
    logic [31:0] last_npc;
    logic        have_last;
    logic        accepted;
    int          stall_left;
    int          idle;
    longint      limit;
    void'($urandom(32'hd797_00dd));
    clock = 1'b0;
    reset = 1'b1;
    instr_valid = 1'b0;
    instr = 32'd0;
    pc = 32'd0;
    stall = 1'b0;
    errors = 0;
    exp_test = "reset";
    exp_valid = 1'b0;
    exp_npc = 32'd0;
    exp_pc = 32'd0;
    exp_we = 1'b0;
    exp_rd = 5'd0;
    exp_wdata = 32'd0;
    for (int i = 0; i < 32; i++)
      mreg[i] = 32'd0;
    m_mepc = 32'd0;
    m_mcause = 32'd0;
    m_mtvec = 32'd0;
    // lui x0 carrying the word index is a no-op that differs everywhere
    for (int i = 0; i < 1024; i++) begin
      imem[i] = {12'(i), 8'd0, 5'd0, 7'b0110111};
      phase_of[i] = 3'd0;
    end

    wp = 0;
    for (int i = 0; i < 200; i++)
      emit(random_alu(), 3'd1);

    emit(enc_i(12'd5, 5'd0, 3'd0, 5'd1, 7'b0010011), 3'd2);
    emit(enc_i(-12'sd3, 5'd0, 3'd0, 5'd2, 7'b0010011), 3'd2);
    emit(enc_b(13'd8, 5'd1, 5'd1, 3'd0), 3'd2);
    emit(enc_i(12'd99, 5'd0, 3'd0, 5'd9, 7'b0010011), 3'd2);
    emit(enc_b(13'd8, 5'd1, 5'd1, 3'd1), 3'd2);
    emit(enc_b(13'd8, 5'd1, 5'd2, 3'd4), 3'd2);
    emit(enc_i(12'd99, 5'd0, 3'd0, 5'd9, 7'b0010011), 3'd2);
    emit(enc_b(13'd8, 5'd1, 5'd2, 3'd6), 3'd2);
    emit(enc_b(13'd8, 5'd2, 5'd1, 3'd5), 3'd2);
    emit(enc_i(12'd99, 5'd0, 3'd0, 5'd9, 7'b0010011), 3'd2);
    emit(enc_b(13'd8, 5'd2, 5'd1, 3'd7), 3'd2);
    emit(enc_j(21'd8, 5'd5), 3'd2);
    emit(enc_i(12'd99, 5'd0, 3'd0, 5'd9, 7'b0010011), 3'd2);
    // odd jalr target two words past the jalr
    emit(enc_i(12'((wp + 3) * 4 + 1), 5'd0, 3'd0, 5'd6, 7'b0010011), 3'd2);
    emit(enc_i(12'd0, 5'd6, 3'd0, 5'd7, 7'b1100111), 3'd2);
    emit(enc_i(12'd99, 5'd0, 3'd0, 5'd9, 7'b0010011), 3'd2);

    emit(enc_i(12'h605, 5'd0, 3'd0, 5'd1, 7'b0010011), 3'd3);
    emit(enc_i(12'h305, 5'd1, 3'd1, 5'd2, 7'b1110011), 3'd3);
    emit(enc_i(12'h0a0, 5'd0, 3'd0, 5'd3, 7'b0010011), 3'd3);
    emit(enc_i(12'h305, 5'd3, 3'd2, 5'd4, 7'b1110011), 3'd3);
    emit(enc_i(12'h305, 5'd3, 3'd3, 5'd10, 7'b1110011), 3'd3);
    emit(enc_i(12'h305, 5'd5, 3'd7, 5'd11, 7'b1110011), 3'd3);
    emit(enc_i(12'd0, 5'd0, 3'd0, 5'd8, 7'b0010011), 3'd3);
    emit(32'h0000_0073, 3'd3);
    emit(enc_i(12'h342, 5'd0, 3'd2, 5'd12, 7'b1110011), 3'd3);

    for (int i = 0; i < 40; i++)
      emit(random_alu(), 3'd4);
    end_pc = wp * 4;

    // trap handler at 0x600 whose first entry returns straight to the ecall
    wp = 384;
    emit(enc_b(13'd12, 5'd0, 5'd8, 3'd1), 3'd3);
    emit(enc_i(12'd1, 5'd0, 3'd0, 5'd8, 7'b0010011), 3'd3);
    emit(32'h3020_0073, 3'd3);
    emit(enc_i(12'h342, 5'd0, 3'd2, 5'd6, 7'b1110011), 3'd3);
    emit(enc_i(12'h341, 5'd0, 3'd2, 5'd7, 7'b1110011), 3'd3);
    emit(enc_i(12'd4, 5'd7, 3'd0, 5'd7, 7'b0010011), 3'd3);
    emit(enc_i(12'h341, 5'd7, 3'd1, 5'd0, 7'b1110011), 3'd3);
    emit(32'h3020_0073, 3'd3);

    limit = (longint'(end_pc / 4 + 8) * 4 + 50) * 40;
    fork
      begin
        #(limit);
        $display("watchdog expired before the program finished");
        $display("Testbench failed");
        $finish;
      end
    join_none

    fetch_pc = 32'd0;
    have_last = 1'b0;
    last_npc = 32'd0;
    stall_left = 0;
    idle = 0;
    repeat (3) @(posedge clock);
    #2;
    reset = 1'b0;
    while (idle < 3) begin
      if (stall_left > 0) begin
        stall = 1'b1;
        stall_left--;
      end else begin
        stall = 1'b0;
        if (phase_of[fetch_pc[11:2]] == 3'd4 && $urandom % 4 == 0)
          stall_left = $urandom % 4 + 1;
      end
      instr_valid = (fetch_pc != end_pc);
      pc = fetch_pc;
      instr = imem[fetch_pc[11:2]];
      @(negedge clock);
      accepted = instr_valid && !stall && !redirect;
      if (accepted) begin
        if (have_last && pc != last_npc)
          report_value("pc_chain", last_npc, pc);
        exec_model(instr, pc);
        last_npc = nxt_npc;
        have_last = 1'b1;
      end
      if (!stall) begin
        if (npc_valid && redirect)
          fetch_pc = npc;
        else if (accepted)
          fetch_pc = fetch_pc + 32'd4;
      end
      if (fetch_pc == end_pc && !accepted)
        idle++;
      @(posedge clock);
      #2;
      if (!stall)
        exp_valid = accepted;
      if (accepted) begin
        exp_test = phase_name(phase_of[pc[11:2]]);
        exp_pc = pc;
        exp_npc = nxt_npc;
        exp_we = nxt_we;
        exp_rd = nxt_rd;
        exp_wdata = nxt_wdata;
      end
    end
    exp_test = "final_state";
    check_state();
    $display("checks done with %0d errors", errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule
